// File: vlog.f
src/zynq_shell_pkg.sv
src/csr_regfile.sv
src/host_window_xlate.sv
src/dram_rebase.sv
src/mem_profiler.sv
src/zynq_shell_top.sv
testbench/tb_clk_gen.sv
testbench/tb_zynq_shell.sv

// File: Bender.yml
package:
  name: zynq_shell

dependencies: {}

sources:
  - src/zynq_shell_pkg.sv
  - src/csr_regfile.sv
  - src/host_window_xlate.sv
  - src/dram_rebase.sv
  - src/mem_profiler.sv
  - src/zynq_shell_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_zynq_shell.sv

// File: testbench/tb_zynq_shell.sv
module tb_zynq_shell;

   localparam int DRAM_W = 64;
   localparam int TIMEOUT = 200;
   localparam logic [31:0] SEED = 32'hd0e3_8652;
   // responders return the address XOR this pattern as read data
   localparam logic [31:0] RD_MASK = 32'h5a5a_5a5a;

   typedef enum logic [1:0] {OP_CSR_WR, OP_CSR_RD, OP_HOST, OP_DRAM} op_kind_e;
   typedef enum {W_RST, W_CSR_ACK, W_HOST_ACK, W_BP_HOST_REQ, W_MEM_REQ, W_DRAM_ACK} wait_sel_e;

   // addr holds the CSR index or the request address
   // exp holds the read value or the translated address
   typedef struct packed {
      op_kind_e    kind;
      logic        we;
      logic        gate;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp;
   } op_t;

   logic                       aclk_i;
   logic                       rst_i;
   logic                       csr_req_i;
   logic                       csr_we_i;
   zynq_shell_pkg::csr_idx_t   csr_addr_i;
   zynq_shell_pkg::word_t      csr_wdata_i;
   logic                       csr_ack_o;
   zynq_shell_pkg::word_t      csr_rdata_o;
   logic                       host_req_i;
   logic                       host_we_i;
   zynq_shell_pkg::host_addr_t host_addr_i;
   zynq_shell_pkg::word_t      host_wdata_i;
   logic                       host_ack_o;
   zynq_shell_pkg::word_t      host_rdata_o;
   logic                       bp_host_req_o;
   logic                       bp_host_we_o;
   zynq_shell_pkg::bp_addr_t   bp_host_addr_o;
   zynq_shell_pkg::word_t      bp_host_wdata_o;
   logic                       bp_host_ack_i;
   zynq_shell_pkg::word_t      bp_host_rdata_i;
   logic                       bp_dram_req_i;
   logic                       bp_dram_we_i;
   zynq_shell_pkg::bp_addr_t   bp_dram_addr_i;
   logic [DRAM_W-1:0]          bp_dram_wdata_i;
   logic                       bp_dram_ack_o;
   logic [DRAM_W-1:0]          bp_dram_rdata_o;
   logic                       mem_req_o;
   logic                       mem_we_o;
   zynq_shell_pkg::bp_addr_t   mem_addr_o;
   logic [DRAM_W-1:0]          mem_wdata_o;
   logic                       mem_ack_i;
   logic [DRAM_W-1:0]          mem_rdata_i;
   logic                       sys_resetn_o;

   op_t         ops[$];
   logic [31:0] data_lfsr;

   tb_clk_gen i_tb_clk_gen (.clk_o(aclk_i), .rst_o(rst_i));

   zynq_shell_top #(.DRAM_DATA_W(DRAM_W)) i_zynq_shell_top (.*);

   ////////////////////////////////////////
   // random bits and failure reporting
   ////////////////////////////////////////

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(inout logic [31:0] state, input int n, output logic [63:0] bits);
      bits = '0;
      for (int i = 0; i < n; i++) begin
         bits = {bits[62:0], state[0]};
         state = lfsr_step(state);
      end
   endtask

   task automatic stop_run();
      $display("RESULT: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input string name, input zynq_shell_pkg::word_t got,
                             input zynq_shell_pkg::word_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bp_addr(input string name, input zynq_shell_pkg::bp_addr_t got,
                                input zynq_shell_pkg::bp_addr_t exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_dram_data(input string name, input logic [DRAM_W-1:0] got,
                                  input logic [DRAM_W-1:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   ////////////////////////////////////////
   // bounded waits on DUT levels
   ////////////////////////////////////////

   function automatic logic watched(input wait_sel_e sel);
      case (sel)
         W_RST:         return rst_i;
         W_CSR_ACK:     return csr_ack_o;
         W_HOST_ACK:    return host_ack_o;
         W_BP_HOST_REQ: return bp_host_req_o;
         W_MEM_REQ:     return mem_req_o;
         default:       return bp_dram_ack_o;
      endcase
   endfunction

   task automatic wait_for(input wait_sel_e sel, input logic level, input string what);
      int n;
      n = 0;
      while (watched(sel) !== level) begin
         @(posedge aclk_i);
         n++;
         if (n > TIMEOUT) begin
            $display("timeout while waiting for %s", what);
            stop_run();
         end
      end
   endtask

   ////////////////////////////////////////
   // responder models
   ////////////////////////////////////////

   initial begin : host_model
      logic [31:0] st;
      logic [63:0] dly;
      st = SEED;
      bp_host_ack_i = 1'b0;
      bp_host_rdata_i = '0;
      forever begin
         @(posedge aclk_i);
         if (bp_host_req_o === 1'b1 && !bp_host_ack_i) begin
            take_bits(st, 3, dly);
            repeat (dly) @(posedge aclk_i);
            bp_host_ack_i   <= 1'b1;
            bp_host_rdata_i <= bp_host_addr_o ^ RD_MASK;
         end else if (bp_host_req_o === 1'b0 && bp_host_ack_i) begin
            bp_host_ack_i <= 1'b0;
         end
      end
   end

   initial begin : mem_model
      logic [31:0] st;
      logic [63:0] dly;
      st = SEED;
      mem_ack_i = 1'b0;
      mem_rdata_i = '0;
      forever begin
         @(posedge aclk_i);
         if (mem_req_o === 1'b1 && !mem_ack_i) begin
            take_bits(st, 3, dly);
            repeat (dly) @(posedge aclk_i);
            mem_ack_i   <= 1'b1;
            mem_rdata_i <= DRAM_W'(mem_addr_o ^ RD_MASK);
         end else if (mem_req_o === 1'b0 && mem_ack_i) begin
            mem_ack_i <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////
   // channel drivers
   ////////////////////////////////////////

   task automatic csr_access(input logic we, input zynq_shell_pkg::csr_idx_t idx,
                             input zynq_shell_pkg::word_t wdata,
                             output zynq_shell_pkg::word_t rdata);
      csr_req_i   <= 1'b1;
      csr_we_i    <= we;
      csr_addr_i  <= idx;
      csr_wdata_i <= wdata;
      wait_for(W_CSR_ACK, 1'b1, "csr ack to rise");
      rdata = csr_rdata_o;
      csr_req_i <= 1'b0;
      wait_for(W_CSR_ACK, 1'b0, "csr ack to fall");
   endtask

   task automatic host_access(input op_t op);
      logic [63:0] bits;
      take_bits(data_lfsr, 32, bits);
      host_req_i   <= 1'b1;
      host_we_i    <= op.we;
      host_addr_i  <= op.addr[29:0];
      host_wdata_i <= bits[31:0];
      wait_for(W_BP_HOST_REQ, 1'b1, "processor host request");
      check_bp_addr("bp_host_addr_o", bp_host_addr_o, op.exp);
      check_bit("bp_host_we_o", bp_host_we_o, op.we);
      if (op.we) begin
         check_word("bp_host_wdata_o", bp_host_wdata_o, bits[31:0]);
      end
      wait_for(W_HOST_ACK, 1'b1, "host ack to rise");
      if (!op.we) begin
         check_word("host_rdata_o", host_rdata_o, op.exp ^ RD_MASK);
      end
      host_req_i <= 1'b0;
      wait_for(W_HOST_ACK, 1'b0, "host ack to fall");
   endtask

   task automatic dram_access(input op_t op);
      logic [63:0]           bits;
      zynq_shell_pkg::word_t unused;
      take_bits(data_lfsr, DRAM_W, bits);
      bp_dram_req_i   <= 1'b1;
      bp_dram_we_i    <= op.we;
      bp_dram_addr_i  <= op.addr;
      bp_dram_wdata_i <= bits[DRAM_W-1:0];
      if (op.gate) begin
         // DRAM not allocated yet so the request must stay parked
         for (int n = 0; n < 20; n++) begin
            @(posedge aclk_i);
            check_bit("mem_req_o", mem_req_o, 1'b0);
         end
         csr_access(1'b1, zynq_shell_pkg::CSR_DRAM_INIT, 32'h1, unused);
      end
      wait_for(W_MEM_REQ, 1'b1, "ARM DRAM request");
      check_bp_addr("mem_addr_o", mem_addr_o, op.exp);
      check_bit("mem_we_o", mem_we_o, op.we);
      if (op.we) begin
         check_dram_data("mem_wdata_o", mem_wdata_o, bits[DRAM_W-1:0]);
      end
      wait_for(W_DRAM_ACK, 1'b1, "processor DRAM ack to rise");
      if (!op.we) begin
         check_dram_data("bp_dram_rdata_o", bp_dram_rdata_o, DRAM_W'(op.exp ^ RD_MASK));
      end
      bp_dram_req_i <= 1'b0;
      wait_for(W_DRAM_ACK, 1'b0, "processor DRAM ack to fall");
   endtask

   ////////////////////////////////////////
   // operation table
   ////////////////////////////////////////

   task automatic add_op(input op_kind_e kind, input logic we, input logic gate,
                         input logic [31:0] addr, input logic [31:0] data,
                         input logic [31:0] exp);
      ops.push_back('{kind, we, gate, addr, data, exp});
   endtask

   task automatic build_table();
      for (int k = 0; k < 8; k++) begin
         add_op(OP_CSR_RD, 1'b0, 1'b0, k, 32'h0, 32'h0);
      end
      add_op(OP_CSR_WR, 1'b0, 1'b0, 32'd0, 32'h0000_0001, 32'h0);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd0, 32'h0, 32'h0000_0001);
      add_op(OP_CSR_WR, 1'b0, 1'b0, 32'd2, 32'h1234_5000, 32'h0);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd2, 32'h0, 32'h1234_5000);
      for (int k = 4; k < 8; k++) begin
         add_op(OP_CSR_WR, 1'b0, 1'b0, k, 32'hffff_ffff, 32'h0);
      end
      for (int k = 3; k < 8; k++) begin
         add_op(OP_CSR_RD, 1'b0, 1'b0, k, 32'h0, 32'h0);
      end
      // bit 29 of the host window picks the DRAM or local half
      add_op(OP_HOST, 1'b1, 1'b0, 32'h0123_4564, 32'h0, 32'h8123_4564);
      add_op(OP_HOST, 1'b0, 1'b0, 32'h0abc_def0, 32'h0, 32'h8abc_def0);
      add_op(OP_HOST, 1'b1, 1'b0, 32'h2000_0010, 32'h0, 32'h0000_0010);
      add_op(OP_HOST, 1'b0, 1'b0, 32'h3fff_fffc, 32'h0, 32'h0fff_fffc);
      // rebased onto base 1234_5000 and touching regions 0 1 32 127 and 66
      add_op(OP_DRAM, 1'b0, 1'b1, 32'h8000_1230, 32'h0, 32'h1234_6230);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd1, 32'h0, 32'h0000_0001);
      add_op(OP_DRAM, 1'b1, 1'b0, 32'h8080_0040, 32'h0, 32'h12b4_5040);
      add_op(OP_DRAM, 1'b0, 1'b0, 32'h9000_0100, 32'h0, 32'h2234_5100);
      add_op(OP_DRAM, 1'b1, 1'b0, 32'hbfff_fff8, 32'h0, 32'h5234_4ff8);
      add_op(OP_DRAM, 1'b0, 1'b0, 32'ha100_0000, 32'h0, 32'h3334_5000);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd4, 32'h0, 32'h0000_0003);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd5, 32'h0, 32'h0000_0001);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd6, 32'h0, 32'h0000_0004);
      add_op(OP_CSR_RD, 1'b0, 1'b0, 32'd7, 32'h0, 32'h8000_0000);
      // system reset clears the profiler map
      add_op(OP_CSR_WR, 1'b0, 1'b0, 32'd0, 32'h0, 32'h0);
      for (int k = 4; k < 8; k++) begin
         add_op(OP_CSR_RD, 1'b0, 1'b0, k, 32'h0, 32'h0);
      end
   endtask

   initial begin
      op_t                   op;
      zynq_shell_pkg::word_t rdata;
      data_lfsr       = SEED;
      csr_req_i       = 1'b0;
      csr_we_i        = 1'b0;
      csr_addr_i      = '0;
      csr_wdata_i     = '0;
      host_req_i      = 1'b0;
      host_we_i       = 1'b0;
      host_addr_i     = '0;
      host_wdata_i    = '0;
      bp_dram_req_i   = 1'b0;
      bp_dram_we_i    = 1'b0;
      bp_dram_addr_i  = '0;
      bp_dram_wdata_i = '0;
      build_table();

      // first edge falls inside the reset pulse
      @(posedge aclk_i);
      wait_for(W_RST, 1'b0, "reset release");
      check_bit("sys_resetn_o", sys_resetn_o, 1'b0);
      check_bit("csr_ack_o", csr_ack_o, 1'b0);
      check_bit("host_ack_o", host_ack_o, 1'b0);
      check_bit("bp_host_req_o", bp_host_req_o, 1'b0);
      check_bit("bp_dram_ack_o", bp_dram_ack_o, 1'b0);
      check_bit("mem_req_o", mem_req_o, 1'b0);

      for (int i = 0; i < ops.size(); i++) begin
         op = ops[i];
         case (op.kind)
            OP_CSR_WR: begin
               csr_access(1'b1, op.addr[2:0], op.data, rdata);
               if (op.addr[2:0] == zynq_shell_pkg::CSR_SYS_RESETN) begin
                  check_bit("sys_resetn_o", sys_resetn_o, op.data[0]);
               end
            end
            OP_CSR_RD: begin
               csr_access(1'b0, op.addr[2:0], 32'h0, rdata);
               check_word("csr_rdata_o", rdata, op.exp);
            end
            OP_HOST: host_access(op);
            default: dram_access(op);
         endcase
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// File: testbench/tb_clk_gen.sv
module tb_clk_gen
  (output logic clk_o
   , output logic rst_o
   );

   // 10 time unit period
   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   // reset held over the first two rising edges
   initial begin
      rst_o = 1'b1;
      repeat (2) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

// File: src/zynq_shell_top.sv
module zynq_shell_top
  #(parameter int DRAM_DATA_W = 64)
  (input  logic                        aclk_i
   , input  logic                      rst_i

   // ARM CSR access
   , input  logic                      csr_req_i
   , input  logic                      csr_we_i
   , input  zynq_shell_pkg::csr_idx_t  csr_addr_i
   , input  zynq_shell_pkg::word_t     csr_wdata_i
   , output logic                      csr_ack_o
   , output zynq_shell_pkg::word_t     csr_rdata_o

   // ARM GP1 host window
   , input  logic                      host_req_i
   , input  logic                      host_we_i
   , input  zynq_shell_pkg::host_addr_t host_addr_i
   , input  zynq_shell_pkg::word_t     host_wdata_i
   , output logic                      host_ack_o
   , output zynq_shell_pkg::word_t     host_rdata_o

   // processor host port
   , output logic                      bp_host_req_o
   , output logic                      bp_host_we_o
   , output zynq_shell_pkg::bp_addr_t  bp_host_addr_o
   , output zynq_shell_pkg::word_t     bp_host_wdata_o
   , input  logic                      bp_host_ack_i
   , input  zynq_shell_pkg::word_t     bp_host_rdata_i

   // processor DRAM requests
   , input  logic                      bp_dram_req_i
   , input  logic                      bp_dram_we_i
   , input  zynq_shell_pkg::bp_addr_t  bp_dram_addr_i
   , input  logic [DRAM_DATA_W-1:0]    bp_dram_wdata_i
   , output logic                      bp_dram_ack_o
   , output logic [DRAM_DATA_W-1:0]    bp_dram_rdata_o

   // ARM DRAM port
   , output logic                      mem_req_o
   , output logic                      mem_we_o
   , output zynq_shell_pkg::bp_addr_t  mem_addr_o
   , output logic [DRAM_DATA_W-1:0]    mem_wdata_o
   , input  logic                      mem_ack_i
   , input  logic [DRAM_DATA_W-1:0]    mem_rdata_i

   // active low processor reset
   , output logic                      sys_resetn_o
   );

   logic                      dram_init;
   zynq_shell_pkg::bp_addr_t  dram_base;
   logic                      issue_v;
   zynq_shell_pkg::bp_addr_t  issue_addr;
   zynq_shell_pkg::prof_map_t prof_map;

   ////////////////////////////////////////
   // control and status registers
   ////////////////////////////////////////

   csr_regfile i_csr_regfile
     (.aclk_i        (aclk_i)
      ,.rst_i        (rst_i)
      ,.csr_req_i    (csr_req_i)
      ,.csr_we_i     (csr_we_i)
      ,.csr_addr_i   (csr_addr_i)
      ,.csr_wdata_i  (csr_wdata_i)
      ,.csr_ack_o    (csr_ack_o)
      ,.csr_rdata_o  (csr_rdata_o)
      ,.prof_map_i   (prof_map)
      ,.sys_resetn_o (sys_resetn_o)
      ,.dram_init_o  (dram_init)
      ,.dram_base_o  (dram_base)
      );

   ////////////////////////////////////////
   // ARM to processor host window
   ////////////////////////////////////////

   host_window_xlate i_host_window_xlate
     (.aclk_i           (aclk_i)
      ,.rst_i           (rst_i)
      ,.host_req_i      (host_req_i)
      ,.host_we_i       (host_we_i)
      ,.host_addr_i     (host_addr_i)
      ,.host_wdata_i    (host_wdata_i)
      ,.host_ack_o      (host_ack_o)
      ,.host_rdata_o    (host_rdata_o)
      ,.bp_host_req_o   (bp_host_req_o)
      ,.bp_host_we_o    (bp_host_we_o)
      ,.bp_host_addr_o  (bp_host_addr_o)
      ,.bp_host_wdata_o (bp_host_wdata_o)
      ,.bp_host_ack_i   (bp_host_ack_i)
      ,.bp_host_rdata_i (bp_host_rdata_i)
      );

   ////////////////////////////////////////
   // processor DRAM path and profiling
   ////////////////////////////////////////

   dram_rebase #(.DRAM_DATA_W(DRAM_DATA_W)) i_dram_rebase
     (.aclk_i           (aclk_i)
      ,.rst_i           (rst_i)
      ,.bp_dram_req_i   (bp_dram_req_i)
      ,.bp_dram_we_i    (bp_dram_we_i)
      ,.bp_dram_addr_i  (bp_dram_addr_i)
      ,.bp_dram_wdata_i (bp_dram_wdata_i)
      ,.bp_dram_ack_o   (bp_dram_ack_o)
      ,.bp_dram_rdata_o (bp_dram_rdata_o)
      ,.mem_req_o       (mem_req_o)
      ,.mem_we_o        (mem_we_o)
      ,.mem_addr_o      (mem_addr_o)
      ,.mem_wdata_o     (mem_wdata_o)
      ,.mem_ack_i       (mem_ack_i)
      ,.mem_rdata_i     (mem_rdata_i)
      ,.dram_init_i     (dram_init)
      ,.dram_base_i     (dram_base)
      ,.issue_v_o       (issue_v)
      ,.issue_addr_o    (issue_addr)
      );

   // profiler map clears together with the processor
   mem_profiler i_mem_profiler
     (.aclk_i        (aclk_i)
      ,.rst_i        (rst_i)
      ,.sys_resetn_i (sys_resetn_o)
      ,.issue_v_i    (issue_v)
      ,.issue_addr_i (issue_addr)
      ,.prof_map_o   (prof_map)
      );

endmodule

// File: src/mem_profiler.sv
module mem_profiler
  (input  logic                        aclk_i
   , input  logic                      rst_i

   // active low system reset from the CSRs
   , input  logic                      sys_resetn_i

   // issued DRAM requests, pre-rebase address
   , input  logic                      issue_v_i
   , input  zynq_shell_pkg::bp_addr_t  issue_addr_i

   , output zynq_shell_pkg::prof_map_t prof_map_o
   );

   logic [zynq_shell_pkg::PROF_REGION_W-1:0] region;
   zynq_shell_pkg::prof_map_t                 region_hit;
   logic                                      map_clear;

   // each region covers 8 MB of the DRAM window
   assign region = issue_addr_i[zynq_shell_pkg::PROF_REGION_MSB -: zynq_shell_pkg::PROF_REGION_W];

   // one-hot of the touched region, empty when nothing was issued
   always_comb begin
      region_hit = '0;
      region_hit[region] = issue_v_i;
   end

   // map is cleared by either reset
   assign map_clear = rst_i | ~sys_resetn_i;

   ////////////////////////////////////////
   // sticky region bitmap
   ////////////////////////////////////////

   always_ff @(posedge aclk_i) begin
      if (map_clear) begin
         prof_map_o <= '0;
      end else begin
         prof_map_o <= prof_map_o | region_hit;
      end
   end

endmodule

// File: src/dram_rebase.sv
module dram_rebase
  #(parameter int DRAM_DATA_W = 64)
  (input  logic                       aclk_i
   , input  logic                     rst_i

   // processor DRAM requests
   , input  logic                     bp_dram_req_i
   , input  logic                     bp_dram_we_i
   , input  zynq_shell_pkg::bp_addr_t bp_dram_addr_i
   , input  logic [DRAM_DATA_W-1:0]   bp_dram_wdata_i
   , output logic                     bp_dram_ack_o
   , output logic [DRAM_DATA_W-1:0]   bp_dram_rdata_o

   // ARM DRAM port
   , output logic                     mem_req_o
   , output logic                     mem_we_o
   , output zynq_shell_pkg::bp_addr_t mem_addr_o
   , output logic [DRAM_DATA_W-1:0]   mem_wdata_o
   , input  logic                     mem_ack_i
   , input  logic [DRAM_DATA_W-1:0]   mem_rdata_i

   // allocation state from the CSRs
   , input  logic                     dram_init_i
   , input  zynq_shell_pkg::bp_addr_t dram_base_i

   // issued request report
   , output logic                     issue_v_o
   , output zynq_shell_pkg::bp_addr_t issue_addr_o
   );

   zynq_shell_pkg::bp_addr_t rebased_addr;
   logic                     fwd_start;
   logic                     ack_start;

   ////////////////////////////////////////
   // address rebase
   ////////////////////////////////////////

   // strip the processor DRAM base, then add the allocated ARM base
   assign rebased_addr = (bp_dram_addr_i ^ zynq_shell_pkg::DRAM_WINDOW_BASE) + dram_base_i;

   // requests wait here until the ARM side has allocated DRAM
   assign fwd_start = bp_dram_req_i & ~bp_dram_ack_o & ~mem_req_o & dram_init_i;
   assign ack_start = mem_ack_i & mem_req_o & ~bp_dram_ack_o;

   ////////////////////////////////////////
   // relay control
   ////////////////////////////////////////

   always_ff @(posedge aclk_i) begin
      if (rst_i) begin
         mem_req_o     <= 1'b0;
         bp_dram_ack_o <= 1'b0;
         issue_v_o     <= 1'b0;
      end else begin
         // one pulse per request, aligned with the rise of mem_req_o
         issue_v_o <= fwd_start;

         if (fwd_start) begin
            mem_req_o <= 1'b1;
         end else if (!bp_dram_req_i) begin
            mem_req_o <= 1'b0;
         end

         if (ack_start) begin
            bp_dram_ack_o <= 1'b1;
         end else if (!mem_ack_i) begin
            bp_dram_ack_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (fwd_start) begin
         mem_we_o     <= bp_dram_we_i;
         mem_addr_o   <= rebased_addr;
         mem_wdata_o  <= bp_dram_wdata_i;
         issue_addr_o <= bp_dram_addr_i;
      end
      if (ack_start) begin
         bp_dram_rdata_o <= mem_rdata_i;
      end
   end

endmodule

// File: src/host_window_xlate.sv
module host_window_xlate
  (input  logic                        aclk_i
   , input  logic                      rst_i

   // ARM GP1 window, requester side
   , input  logic                      host_req_i
   , input  logic                      host_we_i
   , input  zynq_shell_pkg::host_addr_t host_addr_i
   , input  zynq_shell_pkg::word_t     host_wdata_i
   , output logic                      host_ack_o
   , output zynq_shell_pkg::word_t     host_rdata_o

   // processor host port
   , output logic                      bp_host_req_o
   , output logic                      bp_host_we_o
   , output zynq_shell_pkg::bp_addr_t  bp_host_addr_o
   , output zynq_shell_pkg::word_t     bp_host_wdata_o
   , input  logic                      bp_host_ack_i
   , input  zynq_shell_pkg::word_t     bp_host_rdata_i
   );

   zynq_shell_pkg::bp_addr_t xlate_addr;
   logic                     fwd_start;
   logic                     ack_start;

   // window bit 29 low maps to processor DRAM at 8000_0000,
   // high maps to local space at 0000_0000
   always_comb begin
      xlate_addr = '0;
      xlate_addr[zynq_shell_pkg::HOST_OFFSET_W-1:0] =
         host_addr_i[zynq_shell_pkg::HOST_OFFSET_W-1:0];
      xlate_addr[$bits(zynq_shell_pkg::bp_addr_t)-1] =
         ~host_addr_i[zynq_shell_pkg::HOST_WINDOW_SEL_BIT];
   end

   assign fwd_start = host_req_i & ~host_ack_o & ~bp_host_req_o;
   assign ack_start = bp_host_ack_i & bp_host_req_o & ~host_ack_o;

   always_ff @(posedge aclk_i) begin
      if (rst_i) begin
         bp_host_req_o <= 1'b0;
         host_ack_o    <= 1'b0;
      end else begin
         // downstream req follows the upstream req
         if (fwd_start) begin
            bp_host_req_o <= 1'b1;
         end else if (!host_req_i) begin
            bp_host_req_o <= 1'b0;
         end

         // upstream ack follows the downstream ack
         if (ack_start) begin
            host_ack_o <= 1'b1;
         end else if (!bp_host_ack_i) begin
            host_ack_o <= 1'b0;
         end
      end
   end

   always_ff @(posedge aclk_i) begin
      if (fwd_start) begin
         bp_host_we_o    <= host_we_i;
         bp_host_addr_o  <= xlate_addr;
         bp_host_wdata_o <= host_wdata_i;
      end
      if (ack_start) begin
         host_rdata_o <= bp_host_rdata_i;
      end
   end

endmodule

// File: src/csr_regfile.sv
module csr_regfile
  (input  logic                         aclk_i
   , input  logic                       rst_i

   // ARM side register access
   , input  logic                       csr_req_i
   , input  logic                       csr_we_i
   , input  zynq_shell_pkg::csr_idx_t   csr_addr_i
   , input  zynq_shell_pkg::word_t      csr_wdata_i
   , output logic                       csr_ack_o
   , output zynq_shell_pkg::word_t      csr_rdata_o

   // status from the profiler
   , input  zynq_shell_pkg::prof_map_t  prof_map_i

   // control state
   , output logic                       sys_resetn_o
   , output logic                       dram_init_o
   , output zynq_shell_pkg::bp_addr_t   dram_base_o
   );

   zynq_shell_pkg::csr_idx_e csr_idx;
   zynq_shell_pkg::word_t    rd_word;
   logic [1:0]               prof_sel;
   logic                     csr_start;

   logic                     sys_resetn_r;
   logic                     dram_init_r;
   zynq_shell_pkg::bp_addr_t dram_base_r;

   assign csr_idx  = zynq_shell_pkg::csr_idx_e'(csr_addr_i);
   assign prof_sel = csr_addr_i[1:0];

   // a new access is accepted only while the previous ack is low
   assign csr_start = csr_req_i & ~csr_ack_o;

   ////////////////////////////////////////
   // read mux
   ////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      case (csr_idx)
         zynq_shell_pkg::CSR_SYS_RESETN: begin
            rd_word = zynq_shell_pkg::word_t'(sys_resetn_r);
         end
         zynq_shell_pkg::CSR_DRAM_INIT: begin
            rd_word = zynq_shell_pkg::word_t'(dram_init_r);
         end
         zynq_shell_pkg::CSR_DRAM_BASE: begin
            rd_word = dram_base_r;
         end
         zynq_shell_pkg::CSR_PROF0,
         zynq_shell_pkg::CSR_PROF1,
         zynq_shell_pkg::CSR_PROF2,
         zynq_shell_pkg::CSR_PROF3: begin
            rd_word = prof_map_i[prof_sel*zynq_shell_pkg::WORD_W +: zynq_shell_pkg::WORD_W];
         end
         default: begin
            rd_word = '0;
         end
      endcase
   end

   ////////////////////////////////////////
   // handshake and writable registers
   ////////////////////////////////////////

   always_ff @(posedge aclk_i) begin
      if (rst_i) begin
         csr_ack_o    <= 1'b0;
         sys_resetn_r <= 1'b0;
         dram_init_r  <= 1'b0;
         dram_base_r  <= '0;
      end else if (csr_start) begin
         csr_ack_o <= 1'b1;
         if (csr_we_i) begin
            // profiler words and the reserved slot ignore writes
            case (csr_idx)
               zynq_shell_pkg::CSR_SYS_RESETN: sys_resetn_r <= csr_wdata_i[0];
               zynq_shell_pkg::CSR_DRAM_INIT:  dram_init_r  <= csr_wdata_i[0];
               zynq_shell_pkg::CSR_DRAM_BASE:  dram_base_r  <= csr_wdata_i;
               default: begin
               end
            endcase
         end
      end else if (!csr_req_i) begin
         csr_ack_o <= 1'b0;
      end
   end

   // read data is valid while ack is high, a write returns zero
   always_ff @(posedge aclk_i) begin
      if (csr_start) begin
         csr_rdata_o <= csr_we_i ? '0 : rd_word;
      end
   end

   assign sys_resetn_o = sys_resetn_r;
   assign dram_init_o  = dram_init_r;
   assign dram_base_o  = dram_base_r;

endmodule

// File: src/zynq_shell_pkg.sv
package zynq_shell_pkg;

   ////////////////////////////////////////
   // word and address types
   ////////////////////////////////////////

   localparam int WORD_W = 32;

   // CSR and host data word
   typedef logic [WORD_W-1:0] word_t;

   // GP1 window address, top two bits are lost on the ARM port
   typedef logic [29:0] host_addr_t;

   // processor physical address
   typedef logic [31:0] bp_addr_t;

   ////////////////////////////////////////
   // address map constants
   ////////////////////////////////////////

   // picks the DRAM half or the local half of the host window
   localparam int HOST_WINDOW_SEL_BIT = 29;
   localparam int HOST_OFFSET_W = 28;

   // processor DRAM starts here, removed by XOR before rebasing
   localparam bp_addr_t DRAM_WINDOW_BASE = 32'h8000_0000;

   // profiler region index is address bits 29..23
   localparam int PROF_REGION_MSB = 29;
   localparam int PROF_REGION_W = 7;
   localparam int PROF_MAP_W = 2 ** PROF_REGION_W;

   // one bit per region, read back as four words
   typedef logic [PROF_MAP_W-1:0] prof_map_t;

   ////////////////////////////////////////
   // CSR word indices
   ////////////////////////////////////////

   typedef logic [2:0] csr_idx_t;

   // index 3 is reserved and reads zero
   typedef enum csr_idx_t {
      CSR_SYS_RESETN = 3'd0,
      CSR_DRAM_INIT  = 3'd1,
      CSR_DRAM_BASE  = 3'd2,
      CSR_PROF0      = 3'd4,
      CSR_PROF1      = 3'd5,
      CSR_PROF2      = 3'd6,
      CSR_PROF3      = 3'd7
   } csr_idx_e;

endpackage
